// File: sources.f
hdl/picPkg.sv
hdl/picAlu.sv
hdl/fileRam.sv
hdl/ramArbiter.sv
hdl/picSequencer.sv
hdl/picCoreTop.sv
bench/ramArbiter_props.sv
bench/picTb.sv

// File: bench/picTb.sv
/* Testbench for picCoreTop with xorshift stimulus, an instruction server,
   host RAM traffic and a reference model of W, the flags and the RAM */
`default_nettype none

module picTb;

	localparam int addrWidth = 7;
	localparam int depth     = 2 ** addrWidth;
	localparam int waitLimit = 200;  // Cycles before a wait gives up

	logic                 clk;
	logic                 rst;
	logic                 instrReq;
	picPkg::picInstr      instr;
	logic                 instrAck;
	logic                 hostReq;
	logic                 hostWe;
	logic [addrWidth-1:0] hostAddr;
	picPkg::picByte       hostWdata;
	logic                 hostAck;
	picPkg::picByte       hostRdata;
	picPkg::picByte       wReg;
	logic                 c, dc, z, retire;

	picPkg::picByte       modelRam [depth];
	picPkg::picByte       modelW;
	logic                 modelC, modelDc, modelZ;
	logic [31:0]          rngState;
	int                   errors, checks, testsRun, testsPassed, testErrStart;
	bit                   timedOut;
	string                testName;
	logic [31:0]          rnd, hostRnd;
	logic [31:0]          hostRnds [$];
	logic [addrWidth:0]   idx;
	picPkg::picByte       rdVal, hostVal;

	picCoreTop #(.addrWidth(addrWidth)) u_dut (
		.clk, .rst, .instrReq, .instr, .instrAck,
		.hostReq, .hostWe, .hostAddr, .hostWdata, .hostAck, .hostRdata,
		.wReg, .c, .dc, .z, .retire
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	task automatic nextRand(output logic [31:0] v);
		rngState = xorshift(rngState);
		v = rngState;
	endtask

	task automatic checkEq(input string what, input logic [7:0] expected,
		input logic [7:0] actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("** Error %s %s: expected %0h, actual %0h", testName, what,
				expected, actual);
		end
	endtask

	task automatic reportTimeout(input string what);
		timedOut = 1'b1;
		errors++;
		$display("Timeout in %s: %s within %0d cycles", testName, what, waitLimit);
	endtask

	task automatic startTest(input string name);
		testName     = name;
		testErrStart = errors;
		testsRun++;
	endtask

	task automatic finishTest();
		if (errors == testErrStart) begin
			testsPassed++;
		end
		$display("%s: %0d errors", testName, errors - testErrStart);
	endtask

	// Supported words per the opcode tables; bit group allows BCF and BSF only
	function automatic bit isListed(input picPkg::picInstr iw);
		bit ok;
		case (iw[13:8])
			{picPkg::opByte, picPkg::codeAddwf}, {picPkg::opByte, picPkg::codeAndwf},
			{picPkg::opByte, picPkg::codeIncf}, {picPkg::opByte, picPkg::codeIorwf},
			{picPkg::opByte, picPkg::codeDecf}, {picPkg::opByte, picPkg::codeComf},
			{picPkg::opByte, picPkg::codeSubwf}, {picPkg::opByte, picPkg::codeXorwf},
			{picPkg::opLiteral, picPkg::codeAddlw}, {picPkg::opLiteral, picPkg::codeAndlw},
			{picPkg::opLiteral, picPkg::codeIorlw}, {picPkg::opLiteral, picPkg::codeSublw},
			{picPkg::opLiteral, picPkg::codeXorlw}:
				ok = 1'b1;
			default:
				ok = (iw[13:12] == picPkg::opBit) && !iw[11];
		endcase
		return ok;
	endfunction

	// Sum with carry out in bit 8 and nibble carry in bit 9
	function automatic logic [9:0] addWithFlags(input picPkg::picByte a,
		input picPkg::picByte b);
		logic [8:0] s;
		logic [4:0] h;
		s = {1'b0, a} + {1'b0, b};
		h = {1'b0, a[3:0]} + {1'b0, b[3:0]};
		return {h[4], s};
	endfunction

	task automatic modelExec(input picPkg::picInstr iw);
		logic [addrWidth-1:0] a;
		picPkg::picByte       f;
		picPkg::picByte       res;
		picPkg::picByte       negW;
		logic [9:0]           r;
		a    = iw[addrWidth-1:0];
		negW = ~modelW + 8'd1;
		f    = (iw[13:12] == picPkg::opLiteral) ? iw[7:0] : modelRam[a];
		res  = f;
		r    = 10'd0;
		if (isListed(iw) && iw[13:12] == picPkg::opBit) begin
			modelRam[a][iw[9:7]] = (iw[11:10] == picPkg::codeBsf);  // No flag change
		end else if (isListed(iw)) begin
			case (iw[13:8])
				{picPkg::opByte, picPkg::codeAddwf}, {picPkg::opLiteral, picPkg::codeAddlw}: begin
					r       = addWithFlags(f, modelW);
					res     = r[7:0];
					modelC  = r[8];
					modelDc = r[9];
				end
				{picPkg::opByte, picPkg::codeSubwf}, {picPkg::opLiteral, picPkg::codeSublw}: begin
					r       = addWithFlags(f, negW);  // F minus W
					res     = r[7:0];
					modelC  = r[8];
					modelDc = r[9];
				end
				{picPkg::opByte, picPkg::codeAndwf}, {picPkg::opLiteral, picPkg::codeAndlw}:
					res = f & modelW;
				{picPkg::opByte, picPkg::codeIorwf}, {picPkg::opLiteral, picPkg::codeIorlw}:
					res = f | modelW;
				{picPkg::opByte, picPkg::codeXorwf}, {picPkg::opLiteral, picPkg::codeXorlw}:
					res = f ^ modelW;
				{picPkg::opByte, picPkg::codeIncf}: res = f + 8'd1;
				{picPkg::opByte, picPkg::codeDecf}: res = f - 8'd1;
				default:                            res = ~f;  // COMF is the last one
			endcase
			modelZ = (res == 8'h00);
			if (iw[13:12] == picPkg::opByte && iw[7]) begin
				modelRam[a] = res;
			end else begin
				modelW = res;
			end
		end
	endtask

	function automatic picPkg::picInstr byteInstr(input logic [31:0] r);
		logic [3:0] code;
		case (r[18:16])
			3'd0:    code = picPkg::codeAddwf;
			3'd1:    code = picPkg::codeAndwf;
			3'd2:    code = picPkg::codeIncf;
			3'd3:    code = picPkg::codeIorwf;
			3'd4:    code = picPkg::codeDecf;
			3'd5:    code = picPkg::codeComf;
			3'd6:    code = picPkg::codeSubwf;
			default: code = picPkg::codeXorwf;
		endcase
		return {picPkg::opByte, code, r[19], 1'b0, r[5:0]};  // Lower half only
	endfunction

	function automatic picPkg::picInstr litBitInstr(input logic [31:0] r);
		logic [3:0] code;
		case (r[18:16])
			3'd0:    code = picPkg::codeAddlw;
			3'd1:    code = picPkg::codeAndlw;
			3'd2:    code = picPkg::codeIorlw;
			3'd3:    code = picPkg::codeSublw;
			default: code = picPkg::codeXorlw;
		endcase
		if (r[18:16] > 3'd4) begin
			return {picPkg::opBit, 1'b0, r[19], r[22:20], 1'b0, r[5:0]};  // BCF or BSF
		end
		return {picPkg::opLiteral, code, r[7:0]};
	endfunction

	function automatic picPkg::picInstr unlistedInstr(input logic [31:0] r);
		picPkg::picInstr w;
		w = r[13:0];
		if (isListed(w)) begin
			w = {2'b10, r[11:0]};  // Call and goto group
		end
		return w;
	endfunction

	task automatic hostAccess(input logic we, input logic [addrWidth-1:0] addr,
		input picPkg::picByte wdata, output picPkg::picByte rdata);
		int n;
		rdata = 8'h00;
		if (!timedOut) begin
			hostReq   <= 1'b1;
			hostWe    <= we;
			hostAddr  <= addr;
			hostWdata <= wdata;
			n = 0;
			do begin
				@(posedge clk);
				n++;
			end while (!hostAck && n < waitLimit);
			if (!hostAck) begin
				reportTimeout("host ack did not rise");
			end else begin
				rdata = hostRdata;
				hostReq <= 1'b0;
				n = 0;
				do begin
					@(posedge clk);
					n++;
				end while (hostAck && n < waitLimit);
				if (hostAck) begin
					reportTimeout("host ack did not fall");
				end
			end
		end
	endtask

	task automatic verifyRam(input int lo, input int hi);
		logic [addrWidth:0] i;
		picPkg::picByte     v;
		for (i = lo[addrWidth:0]; i < hi; i++) begin
			hostAccess(1'b0, i[addrWidth-1:0], 8'h00, v);
			checkEq($sformatf("ram[%0d]", i), modelRam[i[addrWidth-1:0]], v);
		end
	endtask

	// Serves one word over the instruction port and checks the retire state
	task automatic runInstr(input picPkg::picInstr iw);
		int n;
		if (!timedOut) begin
			n = 0;
			while (!instrReq && n < waitLimit) begin
				@(posedge clk);
				n++;
			end
			if (!instrReq) begin
				reportTimeout("instrReq did not rise");
			end else begin
				instr    <= iw;
				instrAck <= 1'b1;
				n = 0;
				do begin
					@(posedge clk);
					n++;
				end while (instrReq && n < waitLimit);
				instrAck <= 1'b0;
				if (instrReq) begin
					reportTimeout("instrReq did not fall");
				end else begin
					n = 0;
					do begin
						@(posedge clk);
						n++;
					end while (!retire && n < waitLimit);
					if (!retire) begin
						reportTimeout($sformatf("no retire for word %h", iw));
					end else begin
						modelExec(iw);
						checkEq("W", modelW, wReg);
						checkEq("C", modelC, c);
						checkEq("DC", modelDc, dc);
						checkEq("Z", modelZ, z);
					end
				end
			end
		end
	endtask

	initial begin
		rst       = 1'b1;
		instr     = '0;
		instrAck  = 1'b0;
		hostReq   = 1'b0;
		hostWe    = 1'b0;
		hostAddr  = '0;
		hostWdata = '0;
		rngState  = 32'hf8b37a28;
		modelW    = 8'h00;
		modelC    = 1'b0;
		modelDc   = 1'b0;
		modelZ    = 1'b0;
		repeat (5) @(posedge clk);
		rst <= 1'b0;

		startTest("reset_state");
		repeat (8) begin  // No instrAck yet
			@(posedge clk);
			checkEq("retire", 8'd0, retire);
		end
		checkEq("W", 8'h00, wReg);
		checkEq("C", 8'd0, c);
		checkEq("DC", 8'd0, dc);
		checkEq("Z", 8'd0, z);
		finishTest();

		startTest("host_preload");
		for (idx = 0; idx < depth; idx++) begin
			nextRand(rnd);
			modelRam[idx[addrWidth-1:0]] = rnd[7:0];
			hostAccess(1'b1, idx[addrWidth-1:0], rnd[7:0], rdVal);
		end
		verifyRam(0, depth);
		finishTest();

		startTest("byte_ops");
		repeat (64) begin
			nextRand(rnd);
			runInstr(byteInstr(rnd));
		end
		verifyRam(0, depth / 2);
		finishTest();

		startTest("lit_bit_ops");
		repeat (64) begin
			nextRand(rnd);
			runInstr(litBitInstr(rnd));
		end
		verifyRam(0, depth / 2);
		finishTest();

		startTest("contention");
		repeat (40) begin  // Host words drawn up front
			nextRand(hostRnd);
			hostRnds.push_back(hostRnd);
		end
		fork
			repeat (48) begin
				nextRand(rnd);
				runInstr(rnd[31] ? byteInstr(rnd) : litBitInstr(rnd));
			end
			repeat (40) begin
				hostRnd = hostRnds.pop_front();
				repeat (hostRnd[18:16]) @(posedge clk);  // Idle gap
				hostAccess(hostRnd[20], {1'b1, hostRnd[5:0]}, hostRnd[15:8], hostVal);
				if (hostRnd[20]) begin
					modelRam[{1'b1, hostRnd[5:0]}] = hostRnd[15:8];
				end else begin
					checkEq("host read", modelRam[{1'b1, hostRnd[5:0]}], hostVal);
				end
			end
		join
		verifyRam(0, depth);
		finishTest();

		startTest("unlisted");
		repeat (16) begin
			nextRand(rnd);
			runInstr(unlistedInstr(rnd));
		end
		verifyRam(0, depth);
		finishTest();

		$display("%0d of %0d tests passed, %0d checks, %0d errors",
			testsPassed, testsRun, checks, errors);
		if (errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: bench/ramArbiter_props.sv
/* Concurrent handshake assertions for both arbiter ports,
   bound into every ramArbiter instance */
`default_nettype none

module ramArbiterProps (
	input wire logic clk,
	input wire logic rst,
	input wire logic coreReq,
	input wire logic coreAck,
	input wire logic hostReq,
	input wire logic hostAck
);

	coreAckNeedsReq: assert property (@(posedge clk) disable iff (rst)
		$rose(coreAck) |-> coreReq)
		else $error("core ack rose without a core request");

	hostAckNeedsReq: assert property (@(posedge clk) disable iff (rst)
		$rose(hostAck) |-> hostReq)
		else $error("host ack rose without a host request");

	acksExclusive: assert property (@(posedge clk) disable iff (rst)
		!(coreAck && hostAck))
		else $error("core and host acks high together");

	// Ack must follow a dropped request in the next cycle
	coreAckRelease: assert property (@(posedge clk) disable iff (rst)
		$fell(coreReq) |=> !coreAck)
		else $error("core ack held after the core request dropped");

	hostAckRelease: assert property (@(posedge clk) disable iff (rst)
		$fell(hostReq) |=> !hostAck)
		else $error("host ack held after the host request dropped");

endmodule

bind ramArbiter ramArbiterProps uArbProps (
	.clk, .rst, .coreReq, .coreAck, .hostReq, .hostAck
);

`default_nettype wire

// File: hdl/picCoreTop.sv
/* Core top level joining sequencer, ALU, RAM arbiter and file RAM */
`default_nettype none

module picCoreTop #(
	parameter int addrWidth = 7
) (
	input  wire logic                 clk,
	input  wire logic                 rst,
	output logic                      instrReq,
	input  wire picPkg::picInstr      instr,
	input  wire logic                 instrAck,
	input  wire logic                 hostReq,
	input  wire logic                 hostWe,
	input  wire logic [addrWidth-1:0] hostAddr,
	input  wire picPkg::picByte       hostWdata,
	output logic                      hostAck,
	output picPkg::picByte            hostRdata,
	output picPkg::picByte            wReg,
	output logic                      c,
	output logic                      dc,
	output logic                      z,
	output logic                      retire
);

	logic                 coreReq, coreWe, coreAck;
	logic [addrWidth-1:0] coreAddr;
	picPkg::picByte       coreWdata, coreRdata;
	logic                 aluStart, aluDone;
	picPkg::aluOp         op;
	picPkg::picByte       fVal, wVal, result;
	logic [2:0]           bitSel;
	logic                 cIn, dcIn, zIn, cOut, dcOut, zOut;
	logic                 ramWe;
	logic [addrWidth-1:0] ramAddr;
	picPkg::picByte       ramWdata, ramRdata;

	picSequencer #(.addrWidth(addrWidth)) uSeq (
		.clk, .rst, .instrReq, .instr, .instrAck,
		.coreReq, .coreWe, .coreAddr, .coreWdata, .coreAck, .coreRdata,
		.aluStart, .op, .fVal, .wVal, .bitSel, .cIn, .dcIn, .zIn,
		.result, .cOut, .dcOut, .zOut, .aluDone,
		.wReg, .c, .dc, .z, .retire
	);

	picAlu uAlu (
		.clk, .rst, .aluStart, .op, .fVal, .wVal, .bitSel, .cIn, .dcIn, .zIn,
		.result, .cOut, .dcOut, .zOut, .aluDone
	);

	ramArbiter #(.addrWidth(addrWidth)) uArb (
		.clk, .rst,
		.coreReq, .coreWe, .coreAddr, .coreWdata, .coreAck, .coreRdata,
		.hostReq, .hostWe, .hostAddr, .hostWdata, .hostAck, .hostRdata,
		.ramWe, .ramAddr, .ramWdata, .ramRdata
	);

	fileRam #(.addrWidth(addrWidth)) uRam (
		.clk, .we(ramWe), .addr(ramAddr), .wdata(ramWdata), .rdata(ramRdata)
	);

endmodule

`default_nettype wire

// File: hdl/picSequencer.sv
/* Fetch, decode, operand read, execute and writeback FSM
   holding W and the C, DC and Z flags */
`default_nettype none

module picSequencer #(
	parameter int addrWidth = 7
) (
	input  wire logic            clk,
	input  wire logic            rst,
	output logic                 instrReq,
	input  wire picPkg::picInstr instr,
	input  wire logic            instrAck,
	output logic                 coreReq,
	output logic                 coreWe,
	output logic [addrWidth-1:0] coreAddr,
	output picPkg::picByte       coreWdata,
	input  wire logic            coreAck,
	input  wire picPkg::picByte  coreRdata,
	output logic                 aluStart,
	output picPkg::aluOp         op,
	output picPkg::picByte       fVal,
	output picPkg::picByte       wVal,
	output logic [2:0]           bitSel,
	output logic                 cIn,
	output logic                 dcIn,
	output logic                 zIn,
	input  wire picPkg::picByte  result,
	input  wire logic            cOut,
	input  wire logic            dcOut,
	input  wire logic            zOut,
	input  wire logic            aluDone,
	output picPkg::picByte       wReg,
	output logic                 c,
	output logic                 dc,
	output logic                 z,
	output logic                 retire
);

	typedef enum logic [2:0] {
		seqFetch, seqAckWait, seqRead, seqExec, seqWrite, seqRetire
	} seqState;

	seqState         state;
	picPkg::picInstr ir;     // Latched instruction
	picPkg::aluOp    decOp;
	logic            toRam;

	function automatic picPkg::aluOp decode(input picPkg::picInstr i);
		picPkg::aluOp o;
		o = picPkg::aluNop;
		case (i[13:12])
			picPkg::opByte: begin
				case (i[11:8])
					picPkg::codeAddwf: o = picPkg::aluAddwf;
					picPkg::codeAndwf: o = picPkg::aluAndwf;
					picPkg::codeIncf:  o = picPkg::aluIncf;
					picPkg::codeIorwf: o = picPkg::aluIorwf;
					picPkg::codeDecf:  o = picPkg::aluDecf;
					picPkg::codeComf:  o = picPkg::aluComf;
					picPkg::codeSubwf: o = picPkg::aluSubwf;
					picPkg::codeXorwf: o = picPkg::aluXorwf;
					default:           o = picPkg::aluNop;
				endcase
			end
			picPkg::opBit: begin
				case (i[11:10])
					picPkg::codeBcf: o = picPkg::aluBcf;
					picPkg::codeBsf: o = picPkg::aluBsf;
					default:         o = picPkg::aluNop;  // Skips not handled
				endcase
			end
			picPkg::opLiteral: begin
				case (i[11:8])
					picPkg::codeAddlw: o = picPkg::aluAddlw;
					picPkg::codeAndlw: o = picPkg::aluAndlw;
					picPkg::codeIorlw: o = picPkg::aluIorlw;
					picPkg::codeSublw: o = picPkg::aluSublw;
					picPkg::codeXorlw: o = picPkg::aluXorlw;
					default:           o = picPkg::aluNop;
				endcase
			end
			default: o = picPkg::aluNop;
		endcase
		return o;
	endfunction

	assign decOp = decode(ir);

	// Bit ops always write back, byte ops when d is set
	assign toRam = (op == picPkg::aluBcf) || (op == picPkg::aluBsf) ||
		((ir[13:12] == picPkg::opByte) && ir[7]);

	assign coreAddr = ir[addrWidth-1:0];
	assign bitSel   = ir[9:7];
	assign wVal     = wReg;
	assign cIn      = c;
	assign dcIn     = dc;
	assign zIn      = z;
	assign retire   = (state == seqRetire);

	always_ff @(posedge clk) begin
		if (rst) begin
			state    <= seqFetch;
			instrReq <= 1'b0;
			coreReq  <= 1'b0;
			coreWe   <= 1'b0;
			aluStart <= 1'b0;
			wReg     <= 8'h00;
			c        <= 1'b0;
			dc       <= 1'b0;
			z        <= 1'b0;
		end else begin
			aluStart <= 1'b0;
			case (state)
				seqFetch: begin
					if (instrReq && instrAck) begin
						ir       <= instr;
						instrReq <= 1'b0;
						state    <= seqAckWait;
					end else if (!instrAck) begin
						instrReq <= 1'b1;
					end
				end
				seqAckWait: begin
					if (!instrAck) begin
						op   <= decOp;
						fVal <= ir[7:0];  // Literal as F operand
						if (decOp == picPkg::aluNop) begin
							state <= seqRetire;
						end else if (ir[13:12] == picPkg::opLiteral) begin
							aluStart <= 1'b1;
							state    <= seqExec;
						end else begin
							coreWe <= 1'b0;
							state  <= seqRead;
						end
					end
				end
				seqRead: begin
					if (coreReq && coreAck) begin
						fVal     <= coreRdata;
						coreReq  <= 1'b0;
						aluStart <= 1'b1;
						state    <= seqExec;
					end else if (!coreAck) begin
						coreReq <= 1'b1;  // Previous ack has dropped
					end
				end
				seqExec: begin
					if (aluDone) begin
						c  <= cOut;
						dc <= dcOut;
						z  <= zOut;
						if (toRam) begin
							coreWe    <= 1'b1;
							coreWdata <= result;
							state     <= seqWrite;
						end else begin
							wReg  <= result;
							state <= seqRetire;
						end
					end
				end
				seqWrite: begin
					if (coreReq && coreAck) begin
						coreReq <= 1'b0;
						coreWe  <= 1'b0;
						state   <= seqRetire;
					end else if (!coreAck) begin
						coreReq <= 1'b1;
					end
				end
				default: state <= seqFetch;  // Retire pulse
			endcase
		end
	end

endmodule

`default_nettype wire

// File: hdl/ramArbiter.sv
/* Round-robin arbiter that gives the core and host four-phase
   req/ack ports shared access to the file register RAM */
`default_nettype none

module ramArbiter #(
	parameter int addrWidth = 7
) (
	input  wire logic                 clk,
	input  wire logic                 rst,
	input  wire logic                 coreReq,
	input  wire logic                 coreWe,
	input  wire logic [addrWidth-1:0] coreAddr,
	input  wire picPkg::picByte       coreWdata,
	output logic                      coreAck,
	output picPkg::picByte            coreRdata,
	input  wire logic                 hostReq,
	input  wire logic                 hostWe,
	input  wire logic [addrWidth-1:0] hostAddr,
	input  wire picPkg::picByte       hostWdata,
	output logic                      hostAck,
	output picPkg::picByte            hostRdata,
	output logic                      ramWe,
	output logic [addrWidth-1:0]      ramAddr,
	output picPkg::picByte            ramWdata,
	input  wire picPkg::picByte       ramRdata
);

	typedef enum logic [1:0] {arbIdle, arbAccess, arbAck, arbRelease} arbState;

	arbState state;
	logic    servedHost;  // Current or most recent grant went to host
	logic    grantReq;

	assign grantReq = servedHost ? hostReq : coreReq;

	always_ff @(posedge clk) begin
		if (rst) begin
			state      <= arbIdle;
			servedHost <= 1'b1;  // Core wins the first tie
		end else begin
			case (state)
				arbIdle: begin
					if (coreReq || hostReq) begin
						servedHost <= hostReq && (!coreReq || !servedHost);
						state      <= arbAccess;
					end
				end
				arbAccess: state <= arbAck;  // RAM sampled here
				arbAck: begin
					if (!grantReq) begin
						state <= arbRelease;
					end
				end
				default: state <= arbIdle;   // Ack low, grant ends
			endcase
		end
	end

	// Address stays on the granted port so read data holds during ack
	assign ramAddr  = servedHost ? hostAddr : coreAddr;
	assign ramWdata = servedHost ? hostWdata : coreWdata;
	assign ramWe    = (state == arbAccess) && (servedHost ? hostWe : coreWe);

	assign coreAck   = (state == arbAck) && !servedHost;
	assign hostAck   = (state == arbAck) && servedHost;
	assign coreRdata = ramRdata;
	assign hostRdata = ramRdata;

endmodule

`default_nettype wire

// File: hdl/fileRam.sv
/* File register RAM with one write port and a registered read */
`default_nettype none

module fileRam #(
	parameter int addrWidth = 7
) (
	input  wire logic                 clk,
	input  wire logic                 we,
	input  wire logic [addrWidth-1:0] addr,
	input  wire picPkg::picByte       wdata,
	output picPkg::picByte            rdata
);

	localparam int depth = 2 ** addrWidth;

	picPkg::picByte mem [depth];

	always_ff @(posedge clk) begin
		if (we) begin
			mem[addr] <= wdata;
		end
	end

	// Old contents on a read during write
	always_ff @(posedge clk) begin
		rdata <= mem[addr];
	end

endmodule

`default_nettype wire

// File: hdl/picAlu.sv
/* Registered ALU, one operation per start pulse, with result
   and the C, DC and Z flags */
`default_nettype none

module picAlu (
	input  wire logic           clk,
	input  wire logic           rst,
	input  wire logic           aluStart,
	input  var  picPkg::aluOp   op,
	input  wire picPkg::picByte fVal,
	input  wire picPkg::picByte wVal,
	input  wire logic [2:0]     bitSel,
	input  wire logic           cIn,
	input  wire logic           dcIn,
	input  wire logic           zIn,
	output picPkg::picByte      result,
	output logic                cOut,
	output logic                dcOut,
	output logic                zOut,
	output logic                aluDone
);

	picPkg::picByte negW;      // Two's complement of W
	picPkg::picByte bitMask;
	picPkg::picByte nextRes;
	logic [8:0]     addSum;
	logic [8:0]     subSum;
	logic           nextC;
	logic           nextDc;
	logic           updZ;

	assign negW    = ~wVal + 8'd1;
	assign addSum  = {1'b0, fVal} + {1'b0, wVal};
	assign subSum  = {1'b0, fVal} + {1'b0, negW};
	assign bitMask = 8'h01 << bitSel;

	always_comb begin
		nextRes = fVal;
		nextC   = cIn;
		nextDc  = dcIn;
		updZ    = 1'b1;
		case (op)
			picPkg::aluAddwf, picPkg::aluAddlw: begin
				nextRes = addSum[7:0];
				nextC   = addSum[8];
				nextDc  = addSum[4] ^ fVal[4] ^ wVal[4]; // Carry into bit 4
			end
			picPkg::aluSubwf, picPkg::aluSublw: begin
				nextRes = subSum[7:0];  // F minus W
				nextC   = subSum[8];
				nextDc  = subSum[4] ^ fVal[4] ^ negW[4];
			end
			picPkg::aluAndwf, picPkg::aluAndlw: begin
				nextRes = fVal & wVal;
			end
			picPkg::aluIorwf, picPkg::aluIorlw: begin
				nextRes = fVal | wVal;
			end
			picPkg::aluXorwf, picPkg::aluXorlw: begin
				nextRes = fVal ^ wVal;
			end
			picPkg::aluIncf: begin
				nextRes = fVal + 8'd1;
			end
			picPkg::aluDecf: begin
				nextRes = fVal - 8'd1;
			end
			picPkg::aluComf: begin
				nextRes = ~fVal;
			end
			picPkg::aluBcf: begin
				nextRes = fVal & ~bitMask;
				updZ    = 1'b0;          // Bit ops leave all flags
			end
			picPkg::aluBsf: begin
				nextRes = fVal | bitMask;
				updZ    = 1'b0;
			end
			default: begin
				updZ = 1'b0;             // Unlisted op passes F through
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			aluDone <= 1'b0;
		end else begin
			aluDone <= aluStart;  // Exactly one cycle later
		end
	end

	always_ff @(posedge clk) begin
		if (aluStart) begin
			result <= nextRes;
			cOut   <= nextC;
			dcOut  <= nextDc;
			zOut   <= updZ ? (nextRes == 8'h00) : zIn;
		end
	end

endmodule

`default_nettype wire

// File: hdl/picPkg.sv
/* Shared data and instruction types, the ALU operation enum and the
   opcode group and sub-field codes of the 14-bit instruction word */
`default_nettype none

package picPkg;

	typedef logic [7:0]  picByte;   // W, file register and ALU operand
	typedef logic [13:0] picInstr;  // One instruction word

	typedef enum logic [3:0] {
		aluNop,
		aluAddwf, aluAndwf, aluIncf, aluIorwf,
		aluDecf, aluComf, aluSubwf, aluXorwf,
		aluBcf, aluBsf,
		aluAddlw, aluAndlw, aluIorlw, aluSublw, aluXorlw
	} aluOp;

	// Group field, bits 13:12
	localparam logic [1:0] opByte    = 2'b00;
	localparam logic [1:0] opBit     = 2'b01;
	localparam logic [1:0] opLiteral = 2'b11;

	// Byte-oriented codes, bits 11:8
	localparam logic [3:0] codeAddwf = 4'b0111;
	localparam logic [3:0] codeAndwf = 4'b0101;
	localparam logic [3:0] codeIncf  = 4'b1010;
	localparam logic [3:0] codeIorwf = 4'b0100;
	localparam logic [3:0] codeDecf  = 4'b0011;
	localparam logic [3:0] codeComf  = 4'b1001;
	localparam logic [3:0] codeSubwf = 4'b0010;
	localparam logic [3:0] codeXorwf = 4'b0110;

	// Bit-oriented codes, bits 11:10
	localparam logic [1:0] codeBcf = 2'b00;
	localparam logic [1:0] codeBsf = 2'b01;

	// Literal codes, bits 11:8
	localparam logic [3:0] codeAddlw = 4'b1111;
	localparam logic [3:0] codeAndlw = 4'b1001;
	localparam logic [3:0] codeIorlw = 4'b1000;
	localparam logic [3:0] codeSublw = 4'b1101;
	localparam logic [3:0] codeXorlw = 4'b1010;

endpackage

`default_nettype wire
